// File: Makefile
TOP = fetch_tb

.PHONY: compile run clean

compile:
	verilator --binary --assert --timescale 1ns/1ps -f build.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// File: build.f
hw/fetch_pkg.sv
hw/imem_pkg.sv
hw/fetch_stage.sv
hw/branch_predictor.sv
hw/instr_mem.sv
hw/fetch_top.sv
tests/fetch_tb.sv

// File: hw/branch_predictor.sv
module branch_predictor
  import fetch_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic [xlen-1:0] get_pc,
  input  logic            get_branch,
  input  logic            get_return,
  input  logic            get_uncond,
  input  logic [xlen-1:0] upd_pc,
  input  logic [xlen-1:0] upd_npc,
  input  logic [xlen-1:0] upd_addr,
  input  logic            upd_branch,
  input  logic            upd_return,
  input  logic            upd_uncond,
  input  logic            stall,
  input  logic            clear,
  output logic            pred_branch,
  output logic [xlen-1:0] pred_baddr,
  output logic            pred_return,
  output logic [xlen-1:0] pred_raddr,
  output logic            pred_miss,
  output logic [xlen-1:0] pred_maddr
);

  logic [btb_depth-1:0] btb_valid;
  logic [btb_tag_bits-1:0] btb_tag [btb_depth];
  logic [xlen-1:0] btb_target [btb_depth];
  logic [xlen-1:0] ras [ras_depth];
  logic [ras_ptr_bits-1:0] ras_top;
  logic [ras_ptr_bits:0] ras_count;
  logic [btb_index_bits-1:0] get_idx;
  logic [btb_index_bits-1:0] upd_idx;
  logic get_hit;
  logic upd_hit;
  logic upd_jmp;
  logic btb_write;
  logic ras_empty;
  logic push;
  logic pop;

  assign get_idx = get_pc[packet_shift +: btb_index_bits];
  assign upd_idx = upd_pc[packet_shift +: btb_index_bits];
  assign get_hit = btb_valid[get_idx] & (btb_tag[get_idx] == get_pc[xlen-1 -: btb_tag_bits]);
  assign upd_hit = btb_valid[upd_idx] & (btb_tag[upd_idx] == upd_pc[xlen-1 -: btb_tag_bits]);

  assign upd_jmp = upd_branch | upd_uncond;
  assign btb_write = upd_jmp & (upd_addr != upd_npc); // only taken transfers are stored.

  assign pred_branch = (get_branch | get_uncond) & get_hit;
  assign pred_baddr = btb_target[get_idx];
  assign pred_miss = upd_jmp & ~(upd_hit & (btb_target[upd_idx] == upd_addr));
  assign pred_maddr = upd_addr;

  assign ras_empty = (ras_count == '0);
  assign push = upd_return;
  assign pop = get_return & ~ras_empty & ~stall; // a stalled decode repeats its pop later.
  assign pred_return = get_return & ~ras_empty;
  assign pred_raddr = ras[ras_top];

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      btb_valid <= '0;
      ras_top <= '0;
      ras_count <= '0;
    end else begin
      if (btb_write) begin
        btb_valid[upd_idx] <= 1'b1;
      end
      if (clear) begin
        ras_top <= '0;
        ras_count <= '0;
      end else if (push && !pop) begin
        ras_top <= ras_top + 1'b1; // wrapping past the bottom overwrites the oldest entry.
        if (ras_count != (ras_ptr_bits + 1)'(ras_depth)) begin
          ras_count <= ras_count + 1'b1;
        end
      end else if (pop && !push) begin
        ras_top <= ras_top - 1'b1;
        ras_count <= ras_count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (btb_write) begin
      btb_tag[upd_idx] <= upd_pc[xlen-1 -: btb_tag_bits];
      btb_target[upd_idx] <= upd_addr;
    end
    if (push && pop) begin
      ras[ras_top] <= upd_npc; // push and pop together just replace the top.
    end else if (push) begin
      ras[ras_top + 1'b1] <= upd_npc;
    end
  end

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

  localparam int xlen = 32;
  localparam int fetch_bytes = 8;
  localparam int packet_shift = $clog2(fetch_bytes); // byte offset bits inside a packet.

  localparam logic [xlen-1:0] reset_vector = '0;

  // idle waits for clear, busy fetches in order, jump and inv drop one stale response.
  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    jump = 2'd2,
    inv = 2'd3
  } fetch_state_t;

  localparam int btb_depth = 16;
  localparam int btb_index_bits = $clog2(btb_depth);
  localparam int btb_tag_bits = xlen - btb_index_bits - packet_shift;

  localparam int ras_depth = 4;
  localparam int ras_ptr_bits = $clog2(ras_depth);

endpackage

// File: hw/fetch_stage.sv
module fetch_stage
  import fetch_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              trap,
  input  logic [xlen-1:0]   mtvec,
  input  logic              mret,
  input  logic [xlen-1:0]   mepc,
  input  logic              pred_branch,
  input  logic [xlen-1:0]   pred_baddr,
  input  logic              pred_return,
  input  logic [xlen-1:0]   pred_raddr,
  input  logic              pred_miss,
  input  logic [xlen-1:0]   pred_maddr,
  input  logic              exe_jump,
  input  logic [xlen-1:0]   exe_addr,
  input  logic              mem_fence_op,
  input  logic [xlen-1:0]   mem_npc,
  input  logic              stall,
  input  logic              clear,
  input  logic              mem_ready,
  input  logic [2*xlen-1:0] mem_rdata,
  output logic              mem_valid,
  output logic [xlen-1:0]   mem_addr,
  output logic              mem_fence,
  output logic              mem_spec,
  output logic              pred_stall,
  output logic [xlen-1:0]   q_pc,
  output logic [2*xlen-1:0] q_rdata,
  output logic              q_ready
);

  fetch_state_t state;
  fetch_state_t state_next;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_next;
  logic redirect_spec;
  logic redirect_fence;
  logic pend_spec;
  logic pend_fence;
  logic issue;

  // the pc only moves forward when a response is taken in busy and decode is not stalled.
  assign pred_stall = stall | ~((state == busy) & mem_ready);

  always_comb begin
    pc_next = pc;
    redirect_spec = 1'b1;
    redirect_fence = 1'b0;
    if (trap) begin
      pc_next = mtvec;
    end else if (mret) begin
      pc_next = mepc;
    end else if (pred_branch) begin
      pc_next = pred_baddr;
    end else if (pred_return) begin
      pc_next = pred_raddr;
    end else if (pred_miss) begin
      pc_next = pred_maddr;
    end else if (exe_jump) begin
      pc_next = exe_addr;
    end else if (mem_fence_op) begin
      pc_next = mem_npc;
      redirect_fence = 1'b1;
    end else begin
      redirect_spec = 1'b0;
      if (!pred_stall) begin
        pc_next = pc + xlen'(fetch_bytes);
      end
    end
  end

  always_comb begin
    state_next = state;
    issue = 1'b0;
    case (state)
      idle: begin
        if (!clear) begin
          state_next = busy;
          issue = 1'b1;
        end
      end
      busy: begin
        if (mem_ready) begin
          issue = 1'b1;
        end else if (redirect_fence) begin
          state_next = inv; // the fence also counts as speculative, so test it first.
        end else if (redirect_spec) begin
          state_next = jump;
        end
      end
      jump, inv: begin
        if (mem_ready) begin
          state_next = busy; // the stale response is dropped here.
          issue = 1'b1;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  assign mem_valid = issue;
  assign mem_addr = pc_next;
  assign mem_spec = issue & (redirect_spec | pend_spec);
  assign mem_fence = issue & (redirect_fence | pend_fence);

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      state <= idle;
      pc <= reset_vector;
      pend_spec <= 1'b0;
      pend_fence <= 1'b0;
      q_ready <= 1'b0;
    end else begin
      state <= state_next;
      pc <= pc_next;
      pend_spec <= ~issue & (pend_spec | redirect_spec); // held until the redirected request leaves.
      pend_fence <= ~issue & (pend_fence | redirect_fence);
      q_ready <= ~pred_stall;
    end
  end

  always_ff @(posedge clock) begin
    q_pc <= pc; // pc is the address of the request being answered.
    q_rdata <= mem_rdata;
  end

endmodule

// File: hw/fetch_top.sv
module fetch_top
  import fetch_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              trap,
  input  logic [xlen-1:0]   mtvec,
  input  logic              mret,
  input  logic [xlen-1:0]   mepc,
  input  logic [xlen-1:0]   get_pc,
  input  logic              get_branch,
  input  logic              get_return,
  input  logic              get_uncond,
  input  logic [xlen-1:0]   upd_pc,
  input  logic [xlen-1:0]   upd_npc,
  input  logic [xlen-1:0]   upd_addr,
  input  logic              upd_branch,
  input  logic              upd_return,
  input  logic              upd_uncond,
  input  logic              exe_jump,
  input  logic [xlen-1:0]   exe_addr,
  input  logic              mem_fence_op,
  input  logic [xlen-1:0]   mem_npc,
  input  logic              stall,
  input  logic              clear,
  output logic [xlen-1:0]   q_pc,
  output logic [2*xlen-1:0] q_rdata,
  output logic              q_ready
);

  logic pred_branch;
  logic [xlen-1:0] pred_baddr;
  logic pred_return;
  logic [xlen-1:0] pred_raddr;
  logic pred_miss;
  logic [xlen-1:0] pred_maddr;
  logic pred_stall;
  logic mem_valid;
  logic [xlen-1:0] mem_addr;
  logic mem_fence;
  logic mem_spec;
  logic mem_ready;
  logic [2*xlen-1:0] mem_rdata;

  fetch_stage fetch_stage_i (
    .clock        (clock),
    .reset        (reset),
    .trap         (trap),
    .mtvec        (mtvec),
    .mret         (mret),
    .mepc         (mepc),
    .pred_branch  (pred_branch),
    .pred_baddr   (pred_baddr),
    .pred_return  (pred_return),
    .pred_raddr   (pred_raddr),
    .pred_miss    (pred_miss),
    .pred_maddr   (pred_maddr),
    .exe_jump     (exe_jump),
    .exe_addr     (exe_addr),
    .mem_fence_op (mem_fence_op),
    .mem_npc      (mem_npc),
    .stall        (stall),
    .clear        (clear),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata),
    .mem_valid    (mem_valid),
    .mem_addr     (mem_addr),
    .mem_fence    (mem_fence),
    .mem_spec     (mem_spec),
    .pred_stall   (pred_stall),
    .q_pc         (q_pc),
    .q_rdata      (q_rdata),
    .q_ready      (q_ready)
  );

  branch_predictor branch_predictor_i (
    .clock       (clock),
    .reset       (reset),
    .get_pc      (get_pc),
    .get_branch  (get_branch),
    .get_return  (get_return),
    .get_uncond  (get_uncond),
    .upd_pc      (upd_pc),
    .upd_npc     (upd_npc),
    .upd_addr    (upd_addr),
    .upd_branch  (upd_branch),
    .upd_return  (upd_return),
    .upd_uncond  (upd_uncond),
    .stall       (pred_stall), // the fetch stall, so pops wait for fetch to move.
    .clear       (clear),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_return (pred_return),
    .pred_raddr  (pred_raddr),
    .pred_miss   (pred_miss),
    .pred_maddr  (pred_maddr)
  );

  instr_mem instr_mem_i (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_fence (mem_fence),
    .mem_spec  (mem_spec),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

endmodule

// File: hw/imem_pkg.sv
package imem_pkg;

  import fetch_pkg::*;

  localparam int imem_words = 1024;
  localparam int imem_index_bits = $clog2(imem_words);

  localparam int max_latency = 3; // worst case cycles for a miss.
  localparam int lat_bits = $clog2(max_latency + 1);

  localparam logic [xlen-1:0] word_key = xlen'(32'h5a3c_96e1);

  // each packet is two words, derived from the packet address so any fetch is checkable.
  function automatic logic [2*xlen-1:0] instr_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] upper;
    logic [xlen-1:0] lower;
    upper = (addr + xlen'(4)) ^ word_key;
    lower = addr ^ word_key;
    return {upper, lower};
  endfunction

endpackage

// File: hw/instr_mem.sv
module instr_mem
  import fetch_pkg::*;
  import imem_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              mem_valid,
  input  logic [xlen-1:0]   mem_addr,
  input  logic              mem_fence,
  input  logic              mem_spec,
  output logic              mem_ready,
  output logic [2*xlen-1:0] mem_rdata
);

  logic [2*xlen-1:0] mem_array [imem_words];
  logic [imem_index_bits-1:0] req_idx;
  logic req_hit;
  logic pending;
  logic [lat_bits-1:0] remaining;
  logic [lat_bits-1:0] lat_sel;
  logic pf_valid;
  logic [xlen-1:0] pf_addr;
  logic [2*xlen-1:0] pf_data;

  initial begin
    for (int i = 0; i < imem_words; i++) begin
      mem_array[i] = instr_word(xlen'(i * fetch_bytes));
    end
  end

  assign req_idx = mem_addr[packet_shift +: imem_index_bits];
  assign req_hit = pf_valid & ~mem_fence & ~mem_spec & (mem_addr == pf_addr);
  assign mem_ready = pending & (remaining == '0);

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      pending <= 1'b0;
      remaining <= '0;
      lat_sel <= lat_bits'(max_latency);
      pf_valid <= 1'b0;
    end else begin
      if (mem_valid) begin
        pending <= 1'b1;
        remaining <= req_hit ? '0 : lat_sel - 1'b1;
        if (!req_hit) begin
          // miss latency steps down to 2 and starts over at the maximum.
          lat_sel <= (lat_sel == lat_bits'(2)) ? lat_bits'(max_latency) : lat_sel - 1'b1;
        end
        if (mem_fence || mem_spec) begin
          pf_valid <= 1'b0;
        end else if (!req_hit) begin
          pf_valid <= 1'b1;
        end
      end else if (pending) begin
        if (remaining == '0) begin
          pending <= 1'b0;
        end else begin
          remaining <= remaining - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid) begin
      mem_rdata <= req_hit ? pf_data : mem_array[req_idx];
      if (!req_hit) begin
        pf_addr <= mem_addr + xlen'(fetch_bytes); // line after the miss.
        pf_data <= mem_array[req_idx + 1'b1];
      end
    end
  end

endmodule

// File: tests/fetch_tb.sv
module fetch_tb
  import fetch_pkg::*;
  import imem_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic clock;
  logic reset;
  logic trap;
  logic [xlen-1:0] mtvec;
  logic mret;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] get_pc;
  logic get_branch;
  logic get_return;
  logic get_uncond;
  logic [xlen-1:0] upd_pc;
  logic [xlen-1:0] upd_npc;
  logic [xlen-1:0] upd_addr;
  logic upd_branch;
  logic upd_return;
  logic upd_uncond;
  logic exe_jump;
  logic [xlen-1:0] exe_addr;
  logic mem_fence_op;
  logic [xlen-1:0] mem_npc;
  logic stall;
  logic clear;
  logic [xlen-1:0] q_pc;
  logic [2*xlen-1:0] q_rdata;
  logic q_ready;

  logic [31:0] lfsr;
  // bit 0 trap, 1 mret, 2 branch, 3 return, 4 miss, 5 jump, 6 fence.
  logic [6:0] drv_mask;
  logic [6:0][xlen-1:0] drv_tgt;
  logic [6:0] applied_mask;
  logic [6:0][xlen-1:0] applied_tgt;
  string test_name;
  string applied_name;
  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] last_pc;
  int value_errors;
  int timeouts;
  int packets;
  logic [xlen-1:0] ras_model [$];
  logic btb_ok [btb_depth];
  logic [xlen-1:0] btb_pc [btb_depth];
  logic [xlen-1:0] btb_tgt [btb_depth];

  fetch_top fetch_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    int i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic logic [xlen-1:0] random_addr();
    return random_bits(9) << 3; // packet aligned, inside the first 4 KB.
  endfunction

  // the highest priority raised source wins, otherwise fetch moves on by one packet.
  function automatic logic [xlen-1:0] next_fetch(input logic [xlen-1:0] last,
                                                 input logic [6:0] raised,
                                                 input logic [6:0][xlen-1:0] tgt);
    logic [xlen-1:0] addr;
    int i;
    addr = last + xlen'(fetch_bytes);
    for (i = 6; i >= 0; i--) begin
      if (raised[i]) begin
        addr = tgt[i];
      end
    end
    return addr;
  endfunction

  always @(posedge clock) begin
    applied_mask = drv_mask;
    applied_tgt = drv_tgt;
    applied_name = test_name;
  end

  // the packet seen here left before the redirect captured with it.
  always @(negedge clock) begin
    if (q_ready) begin
      packets++;
      assert (q_pc === exp_pc) else begin
        value_errors++;
        $display("ERR %s q_pc expected %h actual %h", applied_name, exp_pc, q_pc);
      end
      assert (q_rdata === instr_word(q_pc)) else begin
        value_errors++;
        $display("ERR %s q_rdata expected %h actual %h", applied_name, instr_word(q_pc),
                 q_rdata);
      end
      last_pc = exp_pc;
      exp_pc = next_fetch(exp_pc, '0, '0);
    end
    if (applied_mask != '0) begin
      exp_pc = next_fetch(last_pc, applied_mask, applied_tgt);
    end
  end

  task automatic next_cycle();
    @(negedge clock);
    trap = 1'b0;
    mret = 1'b0;
    exe_jump = 1'b0;
    mem_fence_op = 1'b0;
    get_branch = 1'b0;
    get_return = 1'b0;
    get_uncond = 1'b0;
    upd_branch = 1'b0;
    upd_return = 1'b0;
    upd_uncond = 1'b0;
    clear = 1'b0;
    drv_mask = '0;
    stall = (random_bits(2) == 32'd3); // decode stalls about one cycle in four.
  endtask

  task automatic run_packets(input int count);
    int seen;
    int guard;
    seen = 0;
    guard = 0;
    while (seen < count && guard < 40 * count) begin
      next_cycle();
      guard++;
      if (q_ready) begin
        seen++;
      end
    end
    assert (seen >= count) else begin
      timeouts++;
      $display("%s: only %0d of %0d packets arrived before the timeout", test_name, seen,
               count);
    end
  endtask

  task automatic csr_redirect(input logic [3:0] forced);
    logic [3:0] pick;
    next_cycle();
    pick = (forced != '0) ? forced : 4'(random_bits(4));
    trap = pick[0];
    mret = pick[1];
    exe_jump = pick[2];
    mem_fence_op = pick[3];
    mtvec = random_addr();
    mepc = random_addr();
    exe_addr = random_addr();
    mem_npc = random_addr();
    drv_tgt[0] = mtvec;
    drv_tgt[1] = mepc;
    drv_tgt[5] = exe_addr;
    drv_tgt[6] = mem_npc;
    drv_mask = {pick[3], pick[2], 3'b000, pick[1], pick[0]};
    run_packets(3);
  endtask

  task automatic train_branch(input logic [xlen-1:0] pc, input logic [xlen-1:0] target);
    logic [btb_index_bits-1:0] idx;
    logic hit;
    idx = pc[packet_shift +: btb_index_bits];
    hit = btb_ok[idx] && btb_pc[idx] == pc && btb_tgt[idx] == target;
    next_cycle();
    upd_pc = pc;
    upd_npc = pc + 8;
    upd_addr = target;
    upd_branch = (random_bits(1) == 32'd1);
    upd_uncond = !upd_branch;
    if (!hit) begin
      drv_mask[4] = 1'b1; // execute resolves a mispredicted jump.
      drv_tgt[4] = target;
    end
    btb_ok[idx] = 1'b1;
    btb_pc[idx] = pc;
    btb_tgt[idx] = target;
    run_packets(3);
  endtask

  task automatic predict_branch(input logic [xlen-1:0] pc);
    logic [btb_index_bits-1:0] idx;
    idx = pc[packet_shift +: btb_index_bits];
    next_cycle();
    get_pc = pc;
    get_branch = (random_bits(1) == 32'd1);
    get_uncond = !get_branch;
    if (btb_ok[idx] && btb_pc[idx] == pc) begin
      drv_mask[2] = 1'b1;
      drv_tgt[2] = btb_tgt[idx];
    end
    run_packets(3);
  endtask

  task automatic push_return(input logic [xlen-1:0] addr);
    next_cycle();
    upd_return = 1'b1;
    upd_npc = addr;
    ras_model.push_back(addr);
    if (ras_model.size() > ras_depth) begin
      ras_model.delete(0); // the oldest entry falls off.
    end
  endtask

  task automatic clear_stack();
    next_cycle();
    clear = 1'b1;
    ras_model.delete();
  endtask

  // a pop only counts when fetch takes a packet in the same cycle.
  task automatic pop_return();
    int guard;
    logic popped;
    popped = 1'b0;
    guard = 0;
    while (!popped && guard < 20) begin
      next_cycle();
      get_return = 1'b1;
      if (ras_model.size() > 0) begin
        drv_mask[3] = 1'b1;
        drv_tgt[3] = ras_model[$];
      end
      next_cycle();
      popped = q_ready || ras_model.size() == 0;
      if (q_ready && ras_model.size() > 0) begin
        ras_model.delete(ras_model.size() - 1);
      end
      run_packets(2);
      guard++;
    end
    assert (popped) else begin
      timeouts++;
      $display("%s: the return stack was never popped", test_name);
    end
  endtask

  initial begin
    int i;
    int j;
    int count;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] other;
    lfsr = 32'hf7d2;
    reset = 1'b0;
    clear = 1'b1;
    stall = 1'b0;
    trap = 1'b0;
    mret = 1'b0;
    exe_jump = 1'b0;
    mem_fence_op = 1'b0;
    mtvec = '0;
    mepc = '0;
    exe_addr = '0;
    mem_npc = '0;
    get_pc = '0;
    get_branch = 1'b0;
    get_return = 1'b0;
    get_uncond = 1'b0;
    upd_pc = '0;
    upd_npc = '0;
    upd_addr = '0;
    upd_branch = 1'b0;
    upd_return = 1'b0;
    upd_uncond = 1'b0;
    drv_mask = '0;
    drv_tgt = '0;
    exp_pc = reset_vector;
    last_pc = reset_vector;
    value_errors = 0;
    timeouts = 0;
    packets = 0;
    test_name = "reset";
    for (i = 0; i < btb_depth; i++) begin
      btb_ok[i] = 1'b0;
    end
    repeat (8) @(negedge clock);
    reset = 1'b1;
    repeat (2) @(negedge clock); // fetch stays idle while clear is high.
    test_name = "sequential";
    run_packets(40);
    test_name = "csr_redirect";
    for (i = 0; i < 24; i++) begin
      csr_redirect((i < 4) ? 4'(1 << i) : 4'b0000);
    end
    test_name = "branch_predict";
    for (i = 0; i < 12; i++) begin
      pc = random_addr();
      target = random_addr();
      if (target == pc + 8) begin
        target = target ^ 32'h40;
      end
      other = target ^ 32'h80;
      if (other == pc + 8) begin
        other = other ^ 32'h100;
      end
      train_branch(pc, target);
      predict_branch(pc);
      train_branch(pc, target);
      train_branch(pc, other);
      predict_branch(pc);
    end
    test_name = "return_stack";
    for (i = 0; i < 6; i++) begin
      count = int'(random_bits(3) % 5) + 1;
      for (j = 0; j < count; j++) begin
        push_return(random_addr());
      end
      if (i % 2 == 1) begin
        clear_stack();
      end
      for (j = 0; j <= count; j++) begin
        pop_return();
      end
    end
    test_name = "sequential_tail";
    run_packets(8);
    $display("packets %0d, value errors %0d, timeouts %0d", packets, value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0 && packets > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
